// File: bus_fabric.f
fabric_bus_pkg.sv
fabric_arb_pkg.sv
mem_bus_if.sv
arb_rr.sv
bus_mux.sv
bus_ram.sv
bus_fabric.sv
tb_bus_fabric_assert.sv
tb_bus_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus fabric testbench with Verilator and runs it
# The run fails if the log holds the failure line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_bus_fabric -f bus_fabric.f \
  -o Vtb_bus_fabric > build.log 2>&1 \
  && ./obj_dir/Vtb_bus_fabric > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log

cat build.log sim.log
! grep -q "Simulation failed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_bus_fabric.sv
// Directed testbench for the shared-memory bus fabric
// Runs single access, rotation, burst lock, hold and random traffic
// A reference memory predicts read data; stops at the first mismatch

`timescale 1ns/1ps

module tb_bus_fabric;

  localparam int MASTERS = fabric_arb_pkg::MASTERS;
  localparam int TIMEOUT = 50;

  logic                                   clk_i = 1'b0;
  logic                                   rst_i;
  fabric_bus_pkg::addr_t [MASTERS-1:0]    m_addr_i;
  fabric_bus_pkg::data_t [MASTERS-1:0]    m_wdata_i;
  logic [MASTERS-1:0]                     m_en_i;
  logic [MASTERS-1:0]                     m_we_i;
  fabric_arb_pkg::grant_t                 m_gnt_o;
  fabric_bus_pkg::data_t                  m_rdata_o;
  logic                                   hold_i;
  logic                                   hold_ack_o;

  // Reference memory and which words hold known data
  fabric_bus_pkg::data_t ref_mem [fabric_bus_pkg::MEM_DEPTH];
  logic                  written [fabric_bus_pkg::MEM_DEPTH];

  // Random source state
  logic [31:0] lfsr;

  bus_fabric dut (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .m_addr_i   (m_addr_i),
    .m_wdata_i  (m_wdata_i),
    .m_en_i     (m_en_i),
    .m_we_i     (m_we_i),
    .m_gnt_o    (m_gnt_o),
    .m_rdata_o  (m_rdata_o),
    .hold_i     (hold_i),
    .hold_ack_o (hold_ack_o)
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic check_data(input fabric_bus_pkg::data_t exp, input string what);
    if (m_rdata_o !== exp) begin
      $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, m_rdata_o);
      fail_run();
    end
  endtask

  task automatic check_grant(input fabric_arb_pkg::grant_t exp_gnt, input logic exp_ack);
    if (m_gnt_o !== exp_gnt || hold_ack_o !== exp_ack) begin
      $display("** Error at %0t ns: grant %b ack %b, expected grant %b ack %b",
               $time, m_gnt_o, hold_ack_o, exp_gnt, exp_ack);
      fail_run();
    end
  endtask

  // Polls the grant at falling edges
  task automatic wait_grant(input int m);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!m_gnt_o[m]) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Master %0d was not granted the bus within %0d cycles", m, TIMEOUT);
        fail_run();
      end
      @(negedge clk_i);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  // One access by master m; keep leaves the enable up for a burst
  task automatic bus_access(input int m, input logic we, input fabric_bus_pkg::addr_t addr,
                            input fabric_bus_pkg::data_t wdata, input logic keep);
    @(posedge clk_i);
    m_en_i[m]    <= 1'b1;
    m_we_i[m]    <= we;
    m_addr_i[m]  <= addr;
    m_wdata_i[m] <= wdata;
    wait_grant(m);
    // Access cycle ends here
    @(posedge clk_i);
    if (!keep) begin
      m_en_i[m] <= 1'b0;
    end
    if (we) begin
      ref_mem[addr] = wdata;
      written[addr] = 1'b1;
    end else begin
      @(negedge clk_i);
      check_data(ref_mem[addr], "read data");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_single_master();
    bus_access(0, 1'b1, 8'h05, 32'hdead_beef, 1'b0);
    bus_access(0, 1'b0, 8'h05, '0, 1'b0);
  endtask

  // Pointer at master 0 after reset, so order is 1 2 3 0
  task automatic test_rotation();
    fabric_arb_pkg::grant_t exp_gnt;
    int                     m;
    apply_reset();
    @(posedge clk_i);
    for (int k = 0; k < MASTERS; k++) begin
      m_en_i[k]    <= 1'b1;
      m_we_i[k]    <= 1'b1;
      m_addr_i[k]  <= fabric_bus_pkg::addr_t'(8'h10 + k);
      m_wdata_i[k] <= fabric_bus_pkg::data_t'(32'h5a5a_0000 + k);
    end
    for (int s = 1; s <= MASTERS; s++) begin
      m       = s % MASTERS;
      exp_gnt = '0;
      exp_gnt[m] = 1'b1;
      @(negedge clk_i);
      check_grant(exp_gnt, 1'b0);
      @(posedge clk_i);
      m_en_i[m] <= 1'b0;
      ref_mem[fabric_bus_pkg::addr_t'(8'h10 + m)] = fabric_bus_pkg::data_t'(32'h5a5a_0000 + m);
      written[fabric_bus_pkg::addr_t'(8'h10 + m)] = 1'b1;
    end
  endtask

  // Master 2 bursts four writes, master 3 waits then reads
  task automatic test_burst_lock();
    fabric_bus_pkg::addr_t cur_addr;
    fabric_bus_pkg::data_t cur_data;
    cur_addr = 8'h20;
    cur_data = 32'hb0b0_0000;
    @(posedge clk_i);
    m_en_i[2]    <= 1'b1;
    m_we_i[2]    <= 1'b1;
    m_addr_i[2]  <= cur_addr;
    m_wdata_i[2] <= cur_data;
    wait_grant(2);
    for (int beat = 0; beat < 4; beat++) begin
      check_grant(4'b0100, 1'b0);
      @(posedge clk_i);
      ref_mem[cur_addr] = cur_data;
      written[cur_addr] = 1'b1;
      if (beat == 0) begin
        m_en_i[3]   <= 1'b1;
        m_we_i[3]   <= 1'b0;
        m_addr_i[3] <= 8'h20;
      end
      if (beat == 3) begin
        m_en_i[2] <= 1'b0;
      end else begin
        cur_addr = cur_addr + 8'd1;
        cur_data = cur_data + 32'd1;
        m_addr_i[2]  <= cur_addr;
        m_wdata_i[2] <= cur_data;
      end
      @(negedge clk_i);
    end
    // Released, master 3 wins in the same cycle
    check_grant(4'b1000, 1'b0);
    @(posedge clk_i);
    m_en_i[3] <= 1'b0;
    @(negedge clk_i);
    check_data(ref_mem[8'h20], "burst word read by master 3");
  endtask

  task automatic test_hold();
    @(posedge clk_i);
    hold_i <= 1'b1;
    @(negedge clk_i);
    check_grant('0, 1'b1);
    @(posedge clk_i);
    m_en_i[1]   <= 1'b1;
    m_we_i[1]   <= 1'b0;
    m_addr_i[1] <= 8'h11;
    repeat (3) begin
      @(negedge clk_i);
      check_grant('0, 1'b1);
      @(posedge clk_i);
    end
    hold_i <= 1'b0;
    wait_grant(1);
    check_grant(4'b0010, 1'b0);
    @(posedge clk_i);
    m_en_i[1] <= 1'b0;
    @(negedge clk_i);
    check_data(ref_mem[8'h11], "read after hold release");
    // Hold raised during a burst waits for the release
    bus_access(0, 1'b1, 8'h30, 32'h0f0f_5a5a, 1'b1);
    hold_i <= 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_grant(4'b0001, 1'b0);
      @(posedge clk_i);
    end
    m_en_i[0] <= 1'b0;
    @(negedge clk_i);
    check_grant('0, 1'b1);
    @(posedge clk_i);
    hold_i <= 1'b0;
    @(negedge clk_i);
    check_grant('0, 1'b0);
  endtask

  // Reads of unknown words turn into writes
  task automatic test_random();
    logic [31:0]           r;
    int                    m;
    logic                  we;
    fabric_bus_pkg::addr_t addr;
    fabric_bus_pkg::data_t data;
    for (int n = 0; n < 40; n++) begin
      take_bits(2, r);
      m = int'(r[1:0]);
      take_bits(1, r);
      we = r[0];
      take_bits(4, r);
      addr = {4'ha, r[3:0]};
      take_bits(32, r);
      data = r;
      if (!we && !written[addr]) begin
        we = 1'b1;
      end
      bus_access(m, we, addr, data, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_i     = 1'b1;
    m_addr_i  = '0;
    m_wdata_i = '0;
    m_en_i    = '0;
    m_we_i    = '0;
    hold_i    = 1'b0;
    lfsr      = 32'hd2dc4112;
    for (int i = 0; i < fabric_bus_pkg::MEM_DEPTH; i++) begin
      written[i] = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    // Idle bus after reset
    @(negedge clk_i);
    check_grant('0, 1'b0);
    test_single_master();
    test_rotation();
    test_burst_lock();
    test_hold();
    test_random();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tb_bus_fabric_assert.sv
// Concurrent checks on the grant logic of the bus mux
// Bound into every bus_mux instance, watches grants, enables
// and the hold handshake at each rising clock edge

`timescale 1ns/1ps

module tb_bus_fabric_assert (
  input logic                                 clk_i,
  input logic                                 rst_i,
  input logic [fabric_arb_pkg::MASTERS-1:0]   en_i,
  input fabric_arb_pkg::grant_t               gnt_i,
  input logic                                 hold_i,
  input logic                                 hold_ack_i
);

  //////////////////////////////////////////////////////////////////////
  // Grant shape and hold
  //////////////////////////////////////////////////////////////////////

  // Never two owners at once
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(gnt_i))
    else $error("grant vector has more than one bit set");

  // Hold request on a bus that nobody locks
  // is acknowledged and leaves the bus unowned
  a_hold_no_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    (hold_i && !(|(en_i & $past(gnt_i)))) |-> (hold_ack_i && (gnt_i == '0)))
    else $error("free bus under hold not acknowledged or still granted");

  //////////////////////////////////////////////////////////////////////
  // Burst lock, one check per master
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < fabric_arb_pkg::MASTERS; i++) begin : g_lock
    // Owner with enable still high keeps the bus next cycle
    a_lock_kept: assert property (@(posedge clk_i) disable iff (rst_i)
      (gnt_i[i] && en_i[i]) |=> (!en_i[i] || gnt_i[i]))
      else $error("locked master lost its grant");
  end

endmodule

bind bus_mux tb_bus_fabric_assert u_assert (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .en_i       (m_en_i),
  .gnt_i      (m_gnt_o),
  .hold_i     (hold_i),
  .hold_ack_i (hold_ack_o)
);

// File: bus_fabric.sv
// Top level of the shared-memory bus fabric
// Four masters with plain packed-array ports share one RAM through a
// round-robin mux; hold_i freezes arbitration whenever the bus is free
// and hold_ack_o reports that the freeze is in effect

`timescale 1ns/1ps

module bus_fabric (
  input  logic                                          clk_i,
  input  logic                                          rst_i,

  // Master request side
  input  fabric_bus_pkg::addr_t [fabric_arb_pkg::MASTERS-1:0] m_addr_i,
  input  fabric_bus_pkg::data_t [fabric_arb_pkg::MASTERS-1:0] m_wdata_i,
  input  logic [fabric_arb_pkg::MASTERS-1:0]           m_en_i,
  input  logic [fabric_arb_pkg::MASTERS-1:0]           m_we_i,

  // Master response side
  output fabric_arb_pkg::grant_t                        m_gnt_o,
  output fabric_bus_pkg::data_t                         m_rdata_o,

  // External bus takeover
  input  logic                                          hold_i,
  output logic                                          hold_ack_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal channel
  //////////////////////////////////////////////////////////////////////

  // Mux to RAM
  mem_bus_if u_bus ();

  //////////////////////////////////////////////////////////////////////
  // Arbitration and routing
  //////////////////////////////////////////////////////////////////////

  bus_mux u_mux (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .m_addr_i   (m_addr_i),
    .m_wdata_i  (m_wdata_i),
    .m_en_i     (m_en_i),
    .m_we_i     (m_we_i),
    .m_gnt_o    (m_gnt_o),
    .m_rdata_o  (m_rdata_o),
    .hold_i     (hold_i),
    .hold_ack_o (hold_ack_o),
    .slv        (u_bus.master)
  );

  //////////////////////////////////////////////////////////////////////
  // Shared memory
  //////////////////////////////////////////////////////////////////////

  bus_ram u_ram (
    .clk_i (clk_i),
    .slv   (u_bus.slave)
  );

endmodule

// File: bus_ram.sv
// Single-port synchronous RAM on the shared bus
// Writes land at the end of the access cycle
// Reads return the addressed word in the following cycle
// Contents are undefined until written

`timescale 1ns/1ps

module bus_ram (
  input logic      clk_i,
  mem_bus_if.slave slv
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // One word per bus address
  fabric_bus_pkg::data_t mem [fabric_bus_pkg::MEM_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Access port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (slv.en) begin
      if (slv.we) begin
        // Write access
        mem[slv.addr] <= slv.wdata;
      end else begin
        // Read access, data valid next cycle
        slv.rdata <= mem[slv.addr];
      end
    end
  end

  // rdata keeps its last value between reads

endmodule

// File: bus_mux.sv
// Master-side multiplexer of the memory fabric
// Tracks the granted master, keeps the bus locked while that master
// holds its enable, answers the external bus-hold request and routes
// the winner onto the slave channel
// Grants are combinational; read data goes to every master

`timescale 1ns/1ps

module bus_mux (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  fabric_bus_pkg::addr_t [fabric_arb_pkg::MASTERS-1:0] m_addr_i,
  input  fabric_bus_pkg::data_t [fabric_arb_pkg::MASTERS-1:0] m_wdata_i,
  input  logic [fabric_arb_pkg::MASTERS-1:0]           m_en_i,
  input  logic [fabric_arb_pkg::MASTERS-1:0]           m_we_i,
  output fabric_arb_pkg::grant_t                        m_gnt_o,
  output fabric_bus_pkg::data_t                         m_rdata_o,
  input  logic                                          hold_i,
  output logic                                          hold_ack_o,
  mem_bus_if.master                                     slv
);

  // Requests seen by the arbiter after lock masking
  logic [fabric_arb_pkg::MASTERS-1:0] m_req;

  // Previous master still holding its enable
  logic locked;

  // Raw arbiter result and its registered copy (priority pointer)
  fabric_arb_pkg::grant_t arb_gnt;
  fabric_arb_pkg::grant_t prev_arb_gnt;

  // Grant actually given last cycle, zero when idle or held
  fabric_arb_pkg::grant_t prev_gnt;

  //////////////////////////////////////////////////////////////////////
  // Lock and hold
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    locked = |(m_en_i & prev_gnt);
    if (locked) begin
      // Burst in progress, only the owner may win
      m_req      = prev_gnt;
      hold_ack_o = 1'b0;
    end else begin
      // Bus free, open to all enables and to the hold request
      m_req      = m_en_i;
      hold_ack_o = hold_i;
    end
  end

  arb_rr #(
    .N (fabric_arb_pkg::MASTERS)
  ) u_arb (
    .req_i     (m_req),
    .gnt_i     (prev_arb_gnt),
    .nxt_gnt_o (arb_gnt)
  );

  // No grant without a live request; nothing at all while held
  assign m_gnt_o = arb_gnt & m_req & {fabric_arb_pkg::MASTERS{~hold_ack_o}};

  //////////////////////////////////////////////////////////////////////
  // Grant history
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prev_gnt     <= '0;
      prev_arb_gnt <= fabric_arb_pkg::GRANT_RESET;
    end else begin
      prev_gnt <= m_gnt_o;
      // Pointer frozen during a hold so the rotation resumes in place
      if (!hold_ack_o) begin
        prev_arb_gnt <= arb_gnt;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slave channel
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Quiet bus when nobody is granted
    slv.addr  = '0;
    slv.wdata = '0;
    slv.we    = 1'b0;
    for (int i = 0; i < fabric_arb_pkg::MASTERS; i++) begin
      if (m_gnt_o[i]) begin
        slv.addr  = m_addr_i[i];
        slv.wdata = m_wdata_i[i];
        slv.we    = m_we_i[i];
      end
    end
  end

  // A grant implies the owner's enable
  assign slv.en = |m_gnt_o;

  // Shared read data, each master qualifies it with its own access
  assign m_rdata_o = slv.rdata;

endmodule

// File: arb_rr.sv
// Round-robin arbiter
// Purely combinational; the caller registers the returned grant and
// feeds it back on gnt_i as the priority pointer for the next cycle
// With no request the previous grant is returned unchanged

`timescale 1ns/1ps

module arb_rr #(
  parameter int N = 4
) (
  input  logic [N-1:0] req_i,
  input  logic [N-1:0] gnt_i,
  output logic [N-1:0] nxt_gnt_o
);

  //////////////////////////////////////////////////////////////////////
  // Rotating priority search
  //////////////////////////////////////////////////////////////////////

  always_comb begin : rotate
    int   ptr;
    int   idx;
    logic found;

    // Last granted index, top index if the pointer is empty
    // so the search then begins at 0
    ptr = N - 1;
    for (int k = 0; k < N; k++) begin
      if (gnt_i[k]) begin
        ptr = k;
      end
    end

    // Keep the old pointer when nobody asks
    nxt_gnt_o = gnt_i;
    found     = 1'b0;

    // Walk from the index after the pointer, wrapping around
    // The pointer itself is visited last
    for (int s = 1; s <= N; s++) begin
      idx = ptr + s;
      if (idx >= N) begin
        idx = idx - N;
      end
      // First requester in rotation order wins
      if (!found && req_i[idx]) begin
        nxt_gnt_o      = '0;
        nxt_gnt_o[idx] = 1'b1;
        found          = 1'b1;
      end
    end
  end

endmodule

// File: mem_bus_if.sv
// Single-cycle memory bus channel
// One instance links the arbitrating mux (master side) to the RAM
// (slave side); read data returns one cycle after the access

`timescale 1ns/1ps

interface mem_bus_if;

  // Request side
  fabric_bus_pkg::addr_t addr;
  fabric_bus_pkg::data_t wdata;
  logic                  en;
  logic                  we;

  // Response side, registered in the slave
  fabric_bus_pkg::data_t rdata;

  // Drives the request and samples read data
  modport master (
    output addr,
    output wdata,
    output en,
    output we,
    input  rdata
  );

  // Accepts the request and returns read data
  modport slave (
    input  addr,
    input  wdata,
    input  en,
    input  we,
    output rdata
  );

endinterface

// File: fabric_arb_pkg.sv
// Arbitration definitions for the memory fabric
// Holds the master count, the one-hot grant vector type and the
// grant value loaded into the round-robin pointer at reset

package fabric_arb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Master side
  //////////////////////////////////////////////////////////////////////

  // Processors sharing the RAM
  localparam int MASTERS = 4;

  // One bit per master, at most one bit set
  typedef logic [MASTERS-1:0] grant_t;

  // Pointer starts at master 0
  // so master 1 wins the first contended round
  localparam grant_t GRANT_RESET = grant_t'(1);

endpackage

// File: fabric_bus_pkg.sv
// Shared bus definitions for the memory fabric
// Covers address and data widths, RAM depth and the bus word types
// Referenced by scoped names from the interface, the mux, the RAM
// and the testbench

package fabric_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////

  // Word address, one RAM word per address
  localparam int ADDR_WIDTH = 8;

  // Full-word data path, no byte selects
  localparam int DATA_WIDTH = 32;

  // RAM covers the whole address space
  localparam int MEM_DEPTH = 256;

  //////////////////////////////////////////////////////////////////////
  // Bus word types
  //////////////////////////////////////////////////////////////////////

  // One bus address
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One bus data word, used for both write and read data
  typedef logic [DATA_WIDTH-1:0] data_t;

endpackage
